// File: source/ctrl_cfg.svh
// Control loop configuration
// Endpoint and port IDs of both ends, and the size of the register bank
// behind the responder

`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// Network identity of the control master
`define CTRL_MASTER_EPID 16'h0001
`define CTRL_MASTER_PORT 10'd1

// Network identity of the responder endpoint
`define CTRL_RESP_EPID   16'h0002
`define CTRL_RESP_PORT   10'd2

// Register bank geometry
`define CTRL_REG_COUNT   16  // Number of 32-bit registers
`define CTRL_REG_AW      4   // Index width, wide enough for CTRL_REG_COUNT

`endif

// File: source/ctrl_pkg.sv
// Control network types
// Opcodes, status codes, the control-port request and response bundles,
// the stream beat and the three word layouts of a control packet

package ctrl_pkg;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  typedef enum logic [3:0] {
    CTRL_OP_WRITE = 4'd1,
    CTRL_OP_READ  = 4'd2
  } ctrl_opcode_t;

  typedef enum logic [1:0] {
    CTRL_STS_OKAY    = 2'd0,
    CTRL_STS_CMDERR  = 2'd1,  // Bad command or address
    CTRL_STS_TSERR   = 2'd2,  // Timestamp problem
    CTRL_STS_WARNING = 2'd3
  } ctrl_status_t;

  // ----------------------------------------
  // Control-port side
  // ----------------------------------------
  typedef struct packed {
    logic        wr;         // Write strobe, one cycle
    logic        rd;         // Read strobe, one cycle
    logic [19:0] addr;
    logic [15:0] epid;       // Destination endpoint
    logic [9:0]  portid;     // Destination port
    logic [31:0] data;
    logic [3:0]  byte_en;
    logic        has_time;
    logic [63:0] timestamp;
  } ctrl_req_t;

  typedef struct packed {
    logic         ack;       // One-cycle pulse
    ctrl_status_t status;
    logic [31:0]  data;
  } ctrl_resp_t;

  // Stream beat, ready travels separately
  typedef struct packed {
    logic [31:0] tdata;
    logic        tlast;
    logic        tvalid;
  } ctrl_beat_t;

  // ----------------------------------------
  // Packet word layouts
  // ----------------------------------------
  typedef struct packed {
    logic        is_ack;
    logic        has_time;
    logic [3:0]  reserved;
    logic [9:0]  dst_port;
    logic [15:0] dst_epid;
  } ctrl_hdr_lo_t;

  typedef struct packed {
    logic [5:0]  seq_num;
    logic [15:0] src_epid;
    logic [9:0]  src_port;
  } ctrl_hdr_hi_t;

  typedef struct packed {
    ctrl_status_t status;
    logic [1:0]   reserved;
    ctrl_opcode_t opcode;
    logic [3:0]   byte_en;
    logic [19:0]  addr;
  } ctrl_op_word_t;

  // One stream word, meaning depends on its position in the packet
  typedef union packed {
    ctrl_hdr_lo_t  hdr_lo;
    ctrl_hdr_hi_t  hdr_hi;
    ctrl_op_word_t op;
    logic [31:0]   raw;
  } ctrl_word_u;

endpackage

// File: source/ctrl_reg_file.sv
// Control register bank
// CTRL_REG_COUNT words of 32 bits, cleared on reset.
// Byte-enabled writes, combinational read

`timescale 1ns/1ps

`include "ctrl_cfg.svh"

module ctrl_reg_file (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    we,
  input  logic [`CTRL_REG_AW-1:0] idx,
  input  logic [31:0]             wdata,
  input  logic [3:0]              be,
  output logic [31:0]             rdata
);

  logic [31:0] regs [`CTRL_REG_COUNT];

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CTRL_REG_COUNT; i++)
        regs[i] <= 32'h0;
    end else if (we && (int'(idx) < `CTRL_REG_COUNT)) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) regs[idx][8*b +: 8] <= wdata[8*b +: 8];  // Only enabled lanes
      end
    end
  end

  // Read port, zero past the end of the bank
  assign rdata = (int'(idx) < `CTRL_REG_COUNT) ? regs[idx] : 32'h0;

endmodule

// File: source/ctrl_master.sv
// Control master
// Control-port slave that turns a read or write strobe into a request
// packet, then parses the response packet into a one-cycle acknowledge.
// Only one transaction is in flight and strobes are ignored while busy

`timescale 1ns/1ps

`include "ctrl_cfg.svh"

module ctrl_master (
  input  logic                 clk,
  input  logic                 rst,
  input  ctrl_pkg::ctrl_req_t  req,
  output ctrl_pkg::ctrl_resp_t resp,
  output ctrl_pkg::ctrl_beat_t req_beat,
  input  logic                 req_ready,
  input  ctrl_pkg::ctrl_beat_t resp_beat,
  output logic                 resp_ready
);
  import ctrl_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_REQ_HDR_LO,
    ST_REQ_HDR_HI,
    ST_REQ_TS_LO,
    ST_REQ_TS_HI,
    ST_REQ_OP,
    ST_REQ_DATA,
    ST_RESP_HDR_LO,
    ST_RESP_HDR_HI,
    ST_RESP_TS_LO,
    ST_RESP_TS_HI,
    ST_RESP_OP,
    ST_RESP_DATA,
    ST_SHORT_PKT    // Response ended early and acks with an error
  } state_t;

  state_t       state;
  logic [5:0]   seq_num;        // Bumped per finished transaction
  ctrl_req_t    req_q;          // Request cached in IDLE
  ctrl_opcode_t req_opcode;
  logic         resp_has_time;  // From response header low
  ctrl_status_t resp_status;    // From response op word
  ctrl_word_u   tx_word;        // Request word being offered
  ctrl_word_u   rx_word;        // Response word being received

  assign req_opcode   = req_q.wr ? CTRL_OP_WRITE : CTRL_OP_READ;
  assign rx_word.raw  = resp_beat.tdata;

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      seq_num <= 6'd0;
    end else begin
      case (state)
        ST_IDLE: if (req.wr || req.rd) state <= ST_REQ_HDR_LO;

        // Request words are held until accepted
        ST_REQ_HDR_LO: if (req_ready) state <= ST_REQ_HDR_HI;
        ST_REQ_HDR_HI: begin
          if (req_ready) state <= req_q.has_time ? ST_REQ_TS_LO : ST_REQ_OP;
        end
        ST_REQ_TS_LO:  if (req_ready) state <= ST_REQ_TS_HI;
        ST_REQ_TS_HI:  if (req_ready) state <= ST_REQ_OP;
        ST_REQ_OP:     if (req_ready) state <= ST_REQ_DATA;
        ST_REQ_DATA:   if (req_ready) state <= ST_RESP_HDR_LO;

        // A tlast before the response data word marks a short packet
        ST_RESP_HDR_LO: begin
          if (resp_beat.tvalid) state <= resp_beat.tlast ? ST_SHORT_PKT : ST_RESP_HDR_HI;
        end
        ST_RESP_HDR_HI: begin
          if (resp_beat.tvalid) begin
            if (resp_beat.tlast)
              state <= ST_SHORT_PKT;
            else
              state <= resp_has_time ? ST_RESP_TS_LO : ST_RESP_OP;
          end
        end
        ST_RESP_TS_LO: begin
          if (resp_beat.tvalid) state <= resp_beat.tlast ? ST_SHORT_PKT : ST_RESP_TS_HI;
        end
        ST_RESP_TS_HI: begin
          if (resp_beat.tvalid) state <= resp_beat.tlast ? ST_SHORT_PKT : ST_RESP_OP;
        end
        ST_RESP_OP: begin
          if (resp_beat.tvalid) state <= resp_beat.tlast ? ST_SHORT_PKT : ST_RESP_DATA;
        end
        ST_RESP_DATA: begin
          if (resp_beat.tvalid) begin
            state   <= ST_IDLE;
            seq_num <= seq_num + 6'd1;
          end
        end
        ST_SHORT_PKT: begin
          state   <= ST_IDLE;
          seq_num <= seq_num + 6'd1;  // Transaction is over either way
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Request and response field capture
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && (req.wr || req.rd))
      req_q <= req;
    if (state == ST_RESP_HDR_LO && resp_beat.tvalid)
      resp_has_time <= rx_word.hdr_lo.has_time;
    if (state == ST_RESP_OP && resp_beat.tvalid)
      resp_status <= rx_word.op.status;
  end

  // ----------------------------------------
  // Request stream
  // ----------------------------------------
  always_comb begin
    tx_word         = '0;   // Reserved fields stay zero
    req_beat.tvalid = 1'b1;
    req_beat.tlast  = 1'b0;
    case (state)
      ST_REQ_HDR_LO: begin
        tx_word.hdr_lo.is_ack   = 1'b0;
        tx_word.hdr_lo.has_time = req_q.has_time;
        tx_word.hdr_lo.dst_port = req_q.portid;
        tx_word.hdr_lo.dst_epid = req_q.epid;
      end
      ST_REQ_HDR_HI: begin
        tx_word.hdr_hi.seq_num  = seq_num;
        tx_word.hdr_hi.src_epid = `CTRL_MASTER_EPID;
        tx_word.hdr_hi.src_port = `CTRL_MASTER_PORT;
      end
      ST_REQ_TS_LO: tx_word.raw = req_q.timestamp[31:0];
      ST_REQ_TS_HI: tx_word.raw = req_q.timestamp[63:32];
      ST_REQ_OP: begin
        tx_word.op.status  = CTRL_STS_OKAY;
        tx_word.op.opcode  = req_opcode;
        tx_word.op.byte_en = req_q.byte_en;
        tx_word.op.addr    = req_q.addr;
      end
      ST_REQ_DATA: begin
        tx_word.raw    = req_q.data;
        req_beat.tlast = 1'b1;  // Last word of the request
      end
      default: req_beat.tvalid = 1'b0;
    endcase
    req_beat.tdata = tx_word.raw;
  end

  // ----------------------------------------
  // Response stream and acknowledge
  // ----------------------------------------
  assign resp_ready = (state inside {ST_RESP_HDR_LO, ST_RESP_HDR_HI, ST_RESP_TS_LO,
                                     ST_RESP_TS_HI, ST_RESP_OP, ST_RESP_DATA});

  always_comb begin
    resp.ack    = (state == ST_RESP_DATA && resp_beat.tvalid) || (state == ST_SHORT_PKT);
    resp.status = (state == ST_SHORT_PKT) ? CTRL_STS_CMDERR : resp_status;
    resp.data   = (state == ST_SHORT_PKT) ? 32'h0 : resp_beat.tdata;  // Data word passes through
  end

endmodule

// File: source/ctrl_responder.sv
// Control responder endpoint
// Receives a request packet, runs it on the register bank and returns a
// response packet of the same layout. A packet for another endpoint gets
// a two-word header-only reply

`timescale 1ns/1ps

`include "ctrl_cfg.svh"

module ctrl_responder (
  input  logic                     clk,
  input  logic                     rst,
  input  ctrl_pkg::ctrl_beat_t     req_beat,
  output logic                     req_ready,
  output ctrl_pkg::ctrl_beat_t     resp_beat,
  input  logic                     resp_ready,
  output logic                     reg_we,
  output logic [`CTRL_REG_AW-1:0]  reg_idx,
  output logic [31:0]              reg_wdata,
  output logic [3:0]               reg_be,
  input  logic [31:0]              reg_rdata
);
  import ctrl_pkg::*;

  typedef enum logic [3:0] {
    ST_RX_HDR_LO, ST_RX_HDR_HI, ST_RX_TS_LO, ST_RX_TS_HI, ST_RX_OP, ST_RX_DATA,
    ST_EXEC,      // One cycle to run the command
    ST_TX_HDR_LO, ST_TX_HDR_HI, ST_TX_TS_LO, ST_TX_TS_HI, ST_TX_OP, ST_TX_DATA
  } state_t;

  state_t       state;
  ctrl_word_u   rx_word, tx_word;
  // Cached request fields
  logic         short_q;      // Wrong endpoint, reply with header only
  logic         has_time_q;
  logic [5:0]   seq_q;
  logic [15:0]  ret_epid_q;   // Requester's endpoint, our reply target
  logic [9:0]   ret_port_q;
  logic [63:0]  ts_q;
  ctrl_opcode_t opcode_q;
  logic [3:0]   be_q;
  logic [19:0]  addr_q;
  logic [31:0]  wdata_q;
  // Execution results
  logic         in_range;
  logic [31:0]  merged;       // Register value after a write
  ctrl_status_t status_q;
  logic [31:0]  result_q;

  assign rx_word.raw = req_beat.tdata;
  assign req_ready   = req_beat.tvalid && (state inside {ST_RX_HDR_LO, ST_RX_HDR_HI,
                       ST_RX_TS_LO, ST_RX_TS_HI, ST_RX_OP, ST_RX_DATA});

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_RX_HDR_LO;
    end else begin
      case (state)
        ST_RX_HDR_LO: if (req_ready) state <= ST_RX_HDR_HI;
        ST_RX_HDR_HI: if (req_ready) state <= has_time_q ? ST_RX_TS_LO : ST_RX_OP;
        ST_RX_TS_LO:  if (req_ready) state <= ST_RX_TS_HI;
        ST_RX_TS_HI:  if (req_ready) state <= ST_RX_OP;
        ST_RX_OP:     if (req_ready) state <= ST_RX_DATA;
        ST_RX_DATA:   if (req_ready) state <= ST_EXEC;
        ST_EXEC:      state <= ST_TX_HDR_LO;
        ST_TX_HDR_LO: if (resp_ready) state <= ST_TX_HDR_HI;
        ST_TX_HDR_HI: begin
          if (resp_ready) begin
            if (short_q) state <= ST_RX_HDR_LO;  // Short reply ends here
            else         state <= has_time_q ? ST_TX_TS_LO : ST_TX_OP;
          end
        end
        ST_TX_TS_LO:  if (resp_ready) state <= ST_TX_TS_HI;
        ST_TX_TS_HI:  if (resp_ready) state <= ST_TX_OP;
        ST_TX_OP:     if (resp_ready) state <= ST_TX_DATA;
        ST_TX_DATA:   if (resp_ready) state <= ST_RX_HDR_LO;
        default:      state <= ST_RX_HDR_LO;
      endcase
    end
  end

  // Field capture by packet position
  always_ff @(posedge clk) begin
    if (req_ready) begin
      case (state)
        ST_RX_HDR_LO: begin
          has_time_q <= rx_word.hdr_lo.has_time;
          short_q    <= (rx_word.hdr_lo.dst_epid != `CTRL_RESP_EPID);
        end
        ST_RX_HDR_HI: begin
          seq_q      <= rx_word.hdr_hi.seq_num;
          ret_epid_q <= rx_word.hdr_hi.src_epid;
          ret_port_q <= rx_word.hdr_hi.src_port;
        end
        ST_RX_TS_LO: ts_q[31:0]  <= rx_word.raw;
        ST_RX_TS_HI: ts_q[63:32] <= rx_word.raw;
        ST_RX_OP: begin
          opcode_q <= rx_word.op.opcode;
          be_q     <= rx_word.op.byte_en;
          addr_q   <= rx_word.op.addr;
        end
        ST_RX_DATA: wdata_q <= rx_word.raw;
        default: ;
      endcase
    end
    if (state == ST_EXEC) begin
      status_q <= in_range ? CTRL_STS_OKAY : CTRL_STS_CMDERR;
      if (!in_range)                   result_q <= 32'h0;
      else if (opcode_q == CTRL_OP_WRITE) result_q <= merged;
      else                             result_q <= reg_rdata;
    end
  end

  // ----------------------------------------
  // Execute
  // ----------------------------------------
  assign in_range = (addr_q < `CTRL_REG_COUNT);

  always_comb begin
    for (int b = 0; b < 4; b++)  // Lane by lane merge
      merged[8*b +: 8] = be_q[b] ? wdata_q[8*b +: 8] : reg_rdata[8*b +: 8];
  end

  assign reg_idx   = addr_q[`CTRL_REG_AW-1:0];
  assign reg_wdata = wdata_q;
  assign reg_be    = be_q;
  assign reg_we    = (state == ST_EXEC) && !short_q && in_range && (opcode_q == CTRL_OP_WRITE);

  // ----------------------------------------
  // Response stream
  // ----------------------------------------
  always_comb begin
    tx_word          = '0;
    resp_beat.tvalid = 1'b1;
    resp_beat.tlast  = 1'b0;
    case (state)
      ST_TX_HDR_LO: begin
        tx_word.hdr_lo.is_ack   = 1'b1;
        tx_word.hdr_lo.has_time = has_time_q;
        tx_word.hdr_lo.dst_port = ret_port_q;
        tx_word.hdr_lo.dst_epid = ret_epid_q;
      end
      ST_TX_HDR_HI: begin
        tx_word.hdr_hi.seq_num  = seq_q;   // Echoed
        tx_word.hdr_hi.src_epid = `CTRL_RESP_EPID;
        tx_word.hdr_hi.src_port = `CTRL_RESP_PORT;
        resp_beat.tlast         = short_q;
      end
      ST_TX_TS_LO: tx_word.raw = ts_q[31:0];
      ST_TX_TS_HI: tx_word.raw = ts_q[63:32];
      ST_TX_OP: begin
        tx_word.op.status  = status_q;
        tx_word.op.opcode  = opcode_q;
        tx_word.op.byte_en = be_q;
        tx_word.op.addr    = addr_q;
      end
      ST_TX_DATA: begin
        tx_word.raw     = result_q;
        resp_beat.tlast = 1'b1;
      end
      default: resp_beat.tvalid = 1'b0;
    endcase
    resp_beat.tdata = tx_word.raw;
  end

endmodule

// File: source/ctrl_loop_top.sv
// Control loop top level
// Control master sends requests to the responder endpoint, which runs
// them on the register bank and answers back to the master

`timescale 1ns/1ps

`include "ctrl_cfg.svh"

module ctrl_loop_top (
  input  logic                 clk,
  input  logic                 rst,
  input  ctrl_pkg::ctrl_req_t  req,
  output ctrl_pkg::ctrl_resp_t resp
);
  import ctrl_pkg::*;

  // Request and response streams
  ctrl_beat_t req_beat;
  logic       req_ready;
  ctrl_beat_t resp_beat;
  logic       resp_ready;

  // Register bank access
  logic                    reg_we;
  logic [`CTRL_REG_AW-1:0] reg_idx;
  logic [31:0]             reg_wdata;
  logic [3:0]              reg_be;
  logic [31:0]             reg_rdata;

  ctrl_master u_master (
    .clk, .rst, .req, .resp,
    .req_beat, .req_ready, .resp_beat, .resp_ready
  );

  ctrl_responder u_responder (
    .clk, .rst,
    .req_beat, .req_ready, .resp_beat, .resp_ready,
    .reg_we, .reg_idx, .reg_wdata, .reg_be, .reg_rdata
  );

  ctrl_reg_file u_regs (
    .clk, .rst,
    .we    (reg_we),
    .idx   (reg_idx),
    .wdata (reg_wdata),
    .be    (reg_be),
    .rdata (reg_rdata)
  );

endmodule

// File: verif/ctrl_loop_tb.sv
// Control loop testbench
// Drives read and write strobes into the control loop and checks every
// acknowledge against a register model kept in the testbench

`timescale 1ns/1ps

`include "ctrl_cfg.svh"

module ctrl_loop_tb;
  import ctrl_pkg::*;

  localparam int ACK_TIMEOUT = 100;  // Cycles allowed per transaction

  logic        clk;
  logic        rst;
  ctrl_req_t   req;
  ctrl_resp_t  resp;
  logic [31:0] model_regs [`CTRL_REG_COUNT];  // Expected bank contents
  ctrl_resp_t  exp_q [$];                     // Expected acks in issue order
  string       name_q [$];
  integer      seed;

  ctrl_loop_top UUT (.clk, .rst, .req, .resp);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_status(input string name, input ctrl_status_t exp,
                              input ctrl_status_t act);
    if (exp !== act)
      stop_on_error($sformatf("Fail %s: expected %s, actual %s (%b)",
                              name, exp.name(), act.name(), act));
  endtask

  task automatic check_data(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    if (exp !== act)
      stop_on_error($sformatf("Fail %s: expected 0x%08h, actual 0x%08h", name, exp, act));
  endtask

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  function automatic ctrl_req_t build_req(input logic wr, input logic [19:0] addr,
                                          input logic [31:0] data, input logic [3:0] be,
                                          input logic [15:0] epid, input logic has_time,
                                          input logic [63:0] ts);
    ctrl_req_t r;
    r.wr        = wr;
    r.rd        = !wr;
    r.addr      = addr;
    r.epid      = epid;
    r.portid    = `CTRL_RESP_PORT;
    r.data      = data;
    r.byte_en   = be;
    r.has_time  = has_time;
    r.timestamp = ts;
    return r;
  endfunction

  // Register model
  // A wrong endpoint or address gives CMDERR and leaves the bank alone
  function automatic ctrl_resp_t ref_access(input ctrl_req_t r);
    ctrl_resp_t  e;
    logic [31:0] cur;
    e.ack    = 1'b1;
    e.status = CTRL_STS_CMDERR;
    e.data   = 32'h0;
    if (r.epid == `CTRL_RESP_EPID && r.addr < `CTRL_REG_COUNT) begin
      cur = model_regs[r.addr];
      for (int b = 0; b < 4; b++) begin
        if (r.wr && r.byte_en[b]) cur[8*b +: 8] = r.data[8*b +: 8];  // Lane merge
      end
      model_regs[r.addr] = cur;
      e.status = CTRL_STS_OKAY;
      e.data   = cur;  // Value after execution
    end
    return e;
  endfunction

  // Pulse the strobe for one cycle and wait for the acknowledge
  task automatic issue_request(input string name, input ctrl_req_t r);
    int cycles;
    bit got;
    exp_q.push_back(ref_access(r));
    name_q.push_back(name);
    @(posedge clk);
    req <= r;
    @(posedge clk);
    req.wr <= 1'b0;
    req.rd <= 1'b0;
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < ACK_TIMEOUT) begin
      @(negedge clk);  // Ack is stable mid-cycle
      got = resp.ack;
      cycles++;
    end
    if (!got)
      stop_on_error($sformatf("No acknowledge for %s within %0d cycles", name, ACK_TIMEOUT));
  endtask

  // ----------------------------------------
  // Compare process
  // ----------------------------------------
  always @(negedge clk) begin
    ctrl_resp_t e;
    string      n;
    if (resp.ack === 1'b1) begin
      if (exp_q.size() == 0) begin
        stop_on_error("Acknowledge seen with no request pending");
      end else begin
        e = exp_q.pop_front();
        n = name_q.pop_front();
        check_status(n, e.status, resp.status);
        check_data(n, e.data, resp.data);
      end
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    logic [19:0] a;
    logic [63:0] ts;
    seed = 8922;
    rst  = 1'b1;
    req  = '0;
    for (int i = 0; i < `CTRL_REG_COUNT; i++) model_regs[i] = 32'h0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < 20; i++) begin  // No ack before the first request
      @(negedge clk);
      if (resp.ack !== 1'b0)
        stop_on_error("Acknowledge not low while idle after reset");
    end

    for (int i = 0; i < `CTRL_REG_COUNT; i++)  // Bank comes up cleared
      issue_request("reset_read",
                    build_req(1'b0, 20'(i), 32'h0, 4'h0, `CTRL_RESP_EPID, 1'b0, 64'h0));

    for (int i = 0; i < `CTRL_REG_COUNT; i++)
      issue_request("full_write",
                    build_req(1'b1, 20'(i), rand32(), 4'hF, `CTRL_RESP_EPID, 1'b0, 64'h0));
    for (int i = 0; i < `CTRL_REG_COUNT; i++)
      issue_request("full_readback",
                    build_req(1'b0, 20'(i), 32'h0, 4'h0, `CTRL_RESP_EPID, 1'b0, 64'h0));

    for (int k = 0; k < 40; k++) begin  // Byte-enabled writes
      a = 20'(rand32() % `CTRL_REG_COUNT);
      issue_request("byte_write",
                    build_req(1'b1, a, rand32(), 4'(rand32()), `CTRL_RESP_EPID, 1'b0, 64'h0));
      issue_request("byte_readback",
                    build_req(1'b0, a, 32'h0, 4'h0, `CTRL_RESP_EPID, 1'b0, 64'h0));
    end

    for (int k = 0; k < 20; k++) begin  // Timestamp only rides along
      a  = 20'(rand32() % `CTRL_REG_COUNT);
      ts = {rand32(), rand32()};
      issue_request("timed_write",
                    build_req(1'b1, a, rand32(), 4'(rand32()), `CTRL_RESP_EPID, 1'b1, ts));
      issue_request("timed_read",
                    build_req(1'b0, a, 32'h0, 4'h0, `CTRL_RESP_EPID, 1'b1, ts));
    end

    for (int k = 0; k < 8; k++) begin  // Past the end of the bank
      a = (k == 0) ? 20'hFFFFF : 20'(`CTRL_REG_COUNT + (rand32() % 64));
      issue_request("range_write",
                    build_req(1'b1, a, rand32(), 4'hF, `CTRL_RESP_EPID, 1'b0, 64'h0));
      issue_request("range_read",
                    build_req(1'b0, a, 32'h0, 4'h0, `CTRL_RESP_EPID, 1'b0, 64'h0));
      a = 20'(a % `CTRL_REG_COUNT);
      issue_request("range_unchanged",
                    build_req(1'b0, a, 32'h0, 4'h0, `CTRL_RESP_EPID, 1'b0, 64'h0));
    end

    // Wrong endpoint gets a short reply
    a = 20'(rand32() % `CTRL_REG_COUNT);
    issue_request("bad_epid", build_req(1'b1, a, rand32(), 4'hF, 16'h0055, 1'b0, 64'h0));
    issue_request("bad_epid_timed", build_req(1'b0, a, 32'h0, 4'h0, 16'hBEEF, 1'b1, 64'h1234));
    issue_request("after_bad_read",
                  build_req(1'b0, a, 32'h0, 4'h0, `CTRL_RESP_EPID, 1'b0, 64'h0));
    issue_request("after_bad_write",
                  build_req(1'b1, a, rand32(), 4'h5, `CTRL_RESP_EPID, 1'b0, 64'h0));

    repeat (4) @(posedge clk);
    if (exp_q.size() != 0) begin
      stop_on_error($sformatf("%0d acknowledges never arrived", exp_q.size()));
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

// File: ctrl_loop_top.f
+incdir+source
source/ctrl_pkg.sv
source/ctrl_reg_file.sv
source/ctrl_master.sv
source/ctrl_responder.sv
source/ctrl_loop_top.sv
verif/ctrl_loop_tb.sv

// File: Makefile
# Verilator build and run for the control loop

VERILATOR ?= verilator
TB_TOP    ?= ctrl_loop_tb
RTL_TOP   ?= ctrl_loop_top
FILELIST  ?= ctrl_loop_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
